/* common/spi_defs.svh */
/*
 * Build-time sizes for the SPI subsystem.
 * Included by the packages and by any RTL file that sizes a port with them.
 */
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// Chip selects on the shared pads
`define SPI_NUM_CS 2

// clk_i cycles per half SCK period
`define SPI_CLK_HALF 2

// Data lines, only 0 and 1 carry data
`define SPI_SD_W 4

`define FLASH_ADDR_W 24
`define REG_ADDR_W 4

`endif

/* common/spi_bus_pkg.sv */
/*
 * Types for the register and memory-read side of the SPI subsystem.
 */
`include "spi_defs.svh"

package spi_bus_pkg;

  // Byte offsets of the host controller registers
  typedef enum logic [`REG_ADDR_W-1:0] {
    REG_CTRL   = 4'h0,
    REG_TXDATA = 4'h4,
    REG_RXDATA = 4'h8,
    REG_STATUS = 4'hC
  } host_reg_e;

  typedef logic [31:0] reg_word_t;

  // Byte address into the serial flash
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;

endpackage

/* common/spi_pad_pkg.sv */
/*
 * Types for the SPI line side: pad vectors, engine states and flash opcodes.
 */
`include "spi_defs.svh"

package spi_pad_pkg;

  // Active low chip selects
  typedef logic [`SPI_NUM_CS-1:0] csb_t;

  typedef logic [`SPI_SD_W-1:0] sd_t;

  typedef enum logic [2:0] {
    FL_IDLE,
    FL_CMD,
    FL_ADDR,
    FL_DATA,
    FL_DONE
  } flash_state_e;

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_SHIFT,
    HS_FINISH
  } host_state_e;

  typedef enum logic [7:0] {
    FLASH_READ = 8'h03
  } flash_opcode_e;

endpackage

/* common/spi_pad_if.sv */
/*
 * Pad signals of one SPI engine. The engine drives the outputs and enables,
 * the pad mux returns the gated incoming data lines.
 */
`timescale 1ns/1ps

interface spi_pad_if;
  import spi_pad_pkg::*;

  logic sck;
  logic sck_en;
  csb_t csb;
  csb_t csb_en;
  sd_t  sd_out;
  sd_t  sd_en;
  sd_t  sd_in;

  modport engine (
    output sck, sck_en, csb, csb_en, sd_out, sd_en,
    input  sd_in
  );

  modport mux (
    input  sck, sck_en, csb, csb_en, sd_out, sd_en,
    output sd_in
  );

endinterface

/* hw/flash_reader/flash_reader.sv */
/*
 * Serial flash read engine. A read pulse sends READ plus a 24-bit address on
 * chip select 0 and returns the next four bytes as one word, lowest address in bits 7:0.
 */
`timescale 1ns/1ps
`include "spi_defs.svh"

module flash_reader (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     rd_req_i,
  input  spi_bus_pkg::flash_addr_t rd_addr_i,
  output logic                     rd_busy_o,
  output logic                     rd_valid_o,
  output spi_bus_pkg::reg_word_t   rd_data_o,
  spi_pad_if.engine                pads
);
  import spi_pad_pkg::*;

  localparam int unsigned DIV_W = $clog2(`SPI_CLK_HALF + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_HALF - 1);

  // Last bit index of each phase, counted on falling SCK edges
  localparam logic [5:0] CMD_LAST  = 6'd7;
  localparam logic [5:0] ADDR_LAST = 6'(7 + `FLASH_ADDR_W);
  localparam logic [5:0] DATA_LAST = 6'(7 + `FLASH_ADDR_W + 32);

  flash_state_e     state_q;
  logic [DIV_W-1:0] div_q;
  logic [5:0]       bit_cnt_q;
  logic [31:0]      shreg_q;
  logic             sck_q;
  logic             cs0_n_q;
  logic             miso_q;
  logic             shifting;
  logic             half_tick;
  logic             rise_tick;
  logic             fall_tick;
  logic             accept;
  logic             mosi;

  assign shifting  = state_q inside {FL_CMD, FL_ADDR, FL_DATA};
  assign half_tick = shifting && (div_q == DIV_LAST);
  assign rise_tick = half_tick && !sck_q;
  assign fall_tick = half_tick && sck_q;
  assign accept    = (state_q == FL_IDLE) && rd_req_i;
  assign rd_busy_o = (state_q != FL_IDLE);

  // Nothing to send once the address is out
  assign mosi = (state_q inside {FL_CMD, FL_ADDR}) ? shreg_q[31] : 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= FL_IDLE;
      div_q      <= '0;
      bit_cnt_q  <= '0;
      sck_q      <= 1'b0;
      cs0_n_q    <= 1'b1;
      miso_q     <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= 1'b0;
      case (state_q)
        FL_IDLE: begin
          if (accept) begin
            state_q   <= FL_CMD;
            cs0_n_q   <= 1'b0;
            div_q     <= '0;
            bit_cnt_q <= '0;
          end
        end
        FL_CMD, FL_ADDR, FL_DATA: begin
          div_q <= half_tick ? '0 : div_q + 1'b1;
          if (rise_tick) begin
            sck_q  <= 1'b1;
            miso_q <= pads.sd_in[1];
          end
          if (fall_tick) begin
            sck_q     <= 1'b0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == CMD_LAST) begin
              state_q <= FL_ADDR;
            end else if (bit_cnt_q == ADDR_LAST) begin
              state_q <= FL_DATA;
            end else if (bit_cnt_q == DATA_LAST) begin
              state_q <= FL_DONE;
            end
          end
        end
        FL_DONE: begin
          cs0_n_q    <= 1'b1;
          rd_valid_o <= 1'b1;
          state_q    <= FL_IDLE;
        end
        default: state_q <= FL_IDLE;
      endcase
    end
  end

  // Bytes arrive first address first, MSB first
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shreg_q <= {FLASH_READ, rd_addr_i};
    end else if (fall_tick) begin
      shreg_q <= {shreg_q[30:0], miso_q};
    end
    if (state_q == FL_DONE) begin
      rd_data_o <= {shreg_q[7:0], shreg_q[15:8], shreg_q[23:16], shreg_q[31:24]};
    end
  end

  assign pads.sck    = sck_q;
  assign pads.sck_en = 1'b1;
  assign pads.csb    = {{(`SPI_NUM_CS-1){1'b1}}, cs0_n_q};
  assign pads.csb_en = '1;
  assign pads.sd_out = {{(`SPI_SD_W-1){1'b0}}, mosi};
  assign pads.sd_en  = {{(`SPI_SD_W-1){1'b0}}, ~cs0_n_q};

endmodule

/* hw/spi_host/spi_host_ctrl.sv */
/*
 * Register-programmed SPI host. CTRL picks the chip select, a TXDATA write
 * starts one full-duplex byte, RXDATA keeps the byte received, STATUS[0] is busy.
 */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_host_ctrl (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  logic [`REG_ADDR_W-1:0] reg_addr_i,
  input  spi_bus_pkg::reg_word_t reg_wdata_i,
  output spi_bus_pkg::reg_word_t reg_rdata_o,
  spi_pad_if.engine              pads
);
  import spi_bus_pkg::*;
  import spi_pad_pkg::*;

  localparam int unsigned CS_IDX_W = $clog2(`SPI_NUM_CS);
  localparam int unsigned DIV_W = $clog2(`SPI_CLK_HALF + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_HALF - 1);

  host_state_e         state_q;
  logic [DIV_W-1:0]    div_q;
  logic [2:0]          bit_cnt_q;
  logic [7:0]          shreg_q;
  logic [CS_IDX_W-1:0] ctrl_cs_q;
  logic [7:0]          txdata_q;
  logic [7:0]          rxdata_q;
  csb_t                csb_q;
  logic                sck_q;
  logic                miso_q;
  logic                busy;
  logic                wr_en;
  logic                rd_en;
  logic                start;
  logic                half_tick;
  logic                rise_tick;
  logic                fall_tick;

  assign busy  = (state_q != HS_IDLE);
  assign wr_en = reg_valid_i && reg_write_i;
  assign rd_en = reg_valid_i && !reg_write_i;

  // TXDATA writes during a transfer are dropped
  assign start = wr_en && (reg_addr_i == REG_TXDATA) && !busy;

  assign half_tick = (state_q == HS_SHIFT) && (div_q == DIV_LAST);
  assign rise_tick = half_tick && !sck_q;
  assign fall_tick = half_tick && sck_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_cs_q <= '0;
      txdata_q  <= '0;
    end else if (wr_en) begin
      if (reg_addr_i == REG_CTRL) begin
        ctrl_cs_q <= reg_wdata_i[CS_IDX_W-1:0];
      end
      if (start) begin
        txdata_q <= reg_wdata_i[7:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rdata_o <= '0;
    end else if (rd_en) begin
      case (reg_addr_i)
        REG_CTRL:   reg_rdata_o <= reg_word_t'(ctrl_cs_q);
        REG_TXDATA: reg_rdata_o <= reg_word_t'(txdata_q);
        REG_RXDATA: reg_rdata_o <= reg_word_t'(rxdata_q);
        REG_STATUS: reg_rdata_o <= reg_word_t'(busy);
        default:    reg_rdata_o <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= HS_IDLE;
      div_q     <= '0;
      bit_cnt_q <= '0;
      csb_q     <= '1;
      sck_q     <= 1'b0;
      miso_q    <= 1'b0;
      rxdata_q  <= '0;
    end else begin
      case (state_q)
        HS_IDLE: begin
          if (start) begin
            state_q   <= HS_SHIFT;
            div_q     <= '0;
            bit_cnt_q <= '0;
            csb_q     <= ~(csb_t'(1) << ctrl_cs_q);
          end
        end
        HS_SHIFT: begin
          div_q <= half_tick ? '0 : div_q + 1'b1;
          if (rise_tick) begin
            sck_q  <= 1'b1;
            miso_q <= pads.sd_in[1];
          end
          if (fall_tick) begin
            sck_q     <= 1'b0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= HS_FINISH;
            end
          end
        end
        HS_FINISH: begin
          // RXDATA lands together with busy going low
          rxdata_q <= shreg_q;
          csb_q    <= '1;
          state_q  <= HS_IDLE;
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  // Same register shifts the TX byte out and the RX byte in
  always_ff @(posedge clk_i) begin
    if (start) begin
      shreg_q <= reg_wdata_i[7:0];
    end else if (fall_tick) begin
      shreg_q <= {shreg_q[6:0], miso_q};
    end
  end

  assign pads.sck    = sck_q;
  assign pads.sck_en = 1'b1;
  assign pads.csb    = csb_q;
  assign pads.csb_en = '1;
  assign pads.sd_out = {{(`SPI_SD_W-1){1'b0}}, (state_q == HS_SHIFT) && shreg_q[7]};
  assign pads.sd_en  = {{(`SPI_SD_W-1){1'b0}}, ~&csb_q};

endmodule

/* hw/spi_pad_mux.sv */
/*
 * Hands the shared SPI pads to one engine. Outputs are registered,
 * incoming data reaches only the selected engine.
 */
`timescale 1ns/1ps

module spi_pad_mux (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              use_flash_i,
  spi_pad_if.mux            flash_pads,
  spi_pad_if.mux            host_pads,
  output logic              spi_sck_o,
  output logic              spi_sck_en_o,
  output spi_pad_pkg::csb_t spi_csb_o,
  output spi_pad_pkg::csb_t spi_csb_en_o,
  output spi_pad_pkg::sd_t  spi_sd_o,
  output spi_pad_pkg::sd_t  spi_sd_en_o,
  input  spi_pad_pkg::sd_t  spi_sd_i
);
  import spi_pad_pkg::*;

  logic sel_sck;
  logic sel_sck_en;
  csb_t sel_csb;
  csb_t sel_csb_en;
  sd_t  sel_sd;
  sd_t  sel_sd_en;

  always_comb begin
    if (use_flash_i) begin
      sel_sck    = flash_pads.sck;
      sel_sck_en = flash_pads.sck_en;
      sel_csb    = flash_pads.csb;
      sel_csb_en = flash_pads.csb_en;
      sel_sd     = flash_pads.sd_out;
      sel_sd_en  = flash_pads.sd_en;
    end else begin
      sel_sck    = host_pads.sck;
      sel_sck_en = host_pads.sck_en;
      sel_csb    = host_pads.csb;
      sel_csb_en = host_pads.csb_en;
      sel_sd     = host_pads.sd_out;
      sel_sd_en  = host_pads.sd_en;
    end
  end

  // Idle pads out of reset: no chip select, SCK low, lines released
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      spi_sck_o    <= 1'b0;
      spi_sck_en_o <= 1'b1;
      spi_csb_o    <= '1;
      spi_csb_en_o <= '1;
      spi_sd_o     <= '0;
      spi_sd_en_o  <= '0;
    end else begin
      spi_sck_o    <= sel_sck;
      spi_sck_en_o <= sel_sck_en;
      spi_csb_o    <= sel_csb;
      spi_csb_en_o <= sel_csb_en;
      spi_sd_o     <= sel_sd;
      spi_sd_en_o  <= sel_sd_en;
    end
  end

  assign flash_pads.sd_in = use_flash_i ? spi_sd_i : '0;
  assign host_pads.sd_in  = use_flash_i ? '0 : spi_sd_i;

endmodule

/* hw/spi_subsystem.sv */
/*
 * SPI subsystem top. The flash reader and the host controller share one
 * set of SPI pads, use_flash_i picks the owner.
 */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_subsystem (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     use_flash_i,

  // Memory-mapped flash read
  input  logic                     rd_req_i,
  input  spi_bus_pkg::flash_addr_t rd_addr_i,
  output logic                     rd_busy_o,
  output logic                     rd_valid_o,
  output spi_bus_pkg::reg_word_t   rd_data_o,

  // Host controller registers
  input  logic                     reg_valid_i,
  input  logic                     reg_write_i,
  input  logic [`REG_ADDR_W-1:0]   reg_addr_i,
  input  spi_bus_pkg::reg_word_t   reg_wdata_i,
  output spi_bus_pkg::reg_word_t   reg_rdata_o,

  // SPI pads
  output logic                     spi_sck_o,
  output logic                     spi_sck_en_o,
  output spi_pad_pkg::csb_t        spi_csb_o,
  output spi_pad_pkg::csb_t        spi_csb_en_o,
  output spi_pad_pkg::sd_t         spi_sd_o,
  output spi_pad_pkg::sd_t         spi_sd_en_o,
  input  spi_pad_pkg::sd_t         spi_sd_i
);

  spi_pad_if flash_pads ();
  spi_pad_if host_pads ();

  flash_reader flash_reader_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_busy_o  (rd_busy_o),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .pads       (flash_pads.engine)
  );

  spi_host_ctrl spi_host_ctrl_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .pads        (host_pads.engine)
  );

  spi_pad_mux spi_pad_mux_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .use_flash_i  (use_flash_i),
    .flash_pads   (flash_pads.mux),
    .host_pads    (host_pads.mux),
    .spi_sck_o    (spi_sck_o),
    .spi_sck_en_o (spi_sck_en_o),
    .spi_csb_o    (spi_csb_o),
    .spi_csb_en_o (spi_csb_en_o),
    .spi_sd_o     (spi_sd_o),
    .spi_sd_en_o  (spi_sd_en_o),
    .spi_sd_i     (spi_sd_i)
  );

endmodule

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock and reset. 10 ns clock, reset low for the first two cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

/* tests/tb_flash_model.sv */
/*
 * SPI slave model on the shared pads. Chip select 0 behaves as a serial flash
 * answering READ, chip select 1 loops MOSI back inverted on MISO.
 */
`timescale 1ns/1ps

module tb_flash_model (
  input  logic              sck_i,
  input  spi_pad_pkg::csb_t csb_i,
  input  spi_pad_pkg::sd_t  sd_i,
  output spi_pad_pkg::sd_t  sd_o
);

  // Opcode and address shifted in MSB first
  logic [31:0] cmd_addr_q;
  int unsigned rise_cnt = 0;
  int unsigned bit_idx;
  logic [7:0]  byte_val;
  logic        flash_miso = 1'b0;

  // Frame ends when chip select 0 goes high again
  always @(posedge sck_i or posedge csb_i[0]) begin
    if (csb_i[0]) begin
      rise_cnt <= 0;
    end else begin
      if (rise_cnt < 32) begin
        cmd_addr_q <= {cmd_addr_q[30:0], sd_i[0]};
      end
      rise_cnt <= rise_cnt + 1;
    end
  end

  // Mode 0 puts the next data bit out on the falling edge
  always @(negedge sck_i) begin
    if (!csb_i[0] && cmd_addr_q[31:24] == 8'h03 && rise_cnt >= 32 && rise_cnt < 64) begin
      bit_idx    = rise_cnt - 32;
      byte_val   = (cmd_addr_q[7:0] + 8'(bit_idx / 8)) ^ 8'h5a;
      flash_miso = byte_val[7 - (bit_idx % 8)];
    end else begin
      flash_miso = 1'b0;
    end
  end

  // MISO is pulled high while no chip select is active
  always_comb begin
    sd_o = '0;
    if (!csb_i[1]) begin
      sd_o[1] = ~sd_i[0];
    end else if (!csb_i[0]) begin
      sd_o[1] = flash_miso;
    end else begin
      sd_o[1] = 1'b1;
    end
  end

endmodule

/* tests/tb_spi_subsystem.sv */
/*
 * Table-driven testbench for the SPI subsystem. Flash reads, host byte transfers
 * and register reads run against the slave model on the shared pads.
 */
`timescale 1ns/1ps
`include "spi_defs.svh"

module tb_spi_subsystem;
  import spi_bus_pkg::*;
  import spi_pad_pkg::*;

  localparam int unsigned CLK_PERIOD_NS = 10;
  localparam int unsigned SCK_PERIOD_NS = 2 * `SPI_CLK_HALF * CLK_PERIOD_NS;
  localparam int unsigned NUM_ROWS = 10;
  localparam int unsigned WATCHDOG_NS = NUM_ROWS * 80 * SCK_PERIOD_NS + 2000;
  localparam int unsigned WAIT_CYCLES = 80 * SCK_PERIOD_NS / CLK_PERIOD_NS;
  localparam int unsigned READ_CYCLES = 70 * SCK_PERIOD_NS / CLK_PERIOD_NS;

  typedef enum logic [1:0] {
    K_FLASH,
    K_FLASH_DBL,
    K_HOST,
    K_REG
  } row_kind_e;

  // arg is the flash address, the TX byte or the CTRL value
  typedef struct packed {
    row_kind_e   kind;
    logic        sel;
    logic [23:0] arg;
    logic [31:0] exp;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{K_REG,       1'b0, 24'h000001, 32'h00000001},
    '{K_REG,       1'b0, 24'h000000, 32'h00000000},
    '{K_FLASH,     1'b1, 24'h000100, 32'h59585b5a},
    '{K_FLASH,     1'b1, 24'h1234fe, 32'h5b5aa5a4},
    '{K_HOST,      1'b0, 24'h0000a5, 32'h0000005a},
    '{K_HOST,      1'b0, 24'h00003c, 32'h000000c3},
    '{K_FLASH,     1'b0, 24'habcd10, 32'h00000000},
    '{K_FLASH_DBL, 1'b1, 24'habcd10, 32'h49484b4a},
    '{K_HOST,      1'b0, 24'h000001, 32'h000000fe},
    '{K_FLASH,     1'b1, 24'h0000ff, 32'h585b5aa5}
  };

  logic                   clk;
  logic                   arst_n;
  logic                   use_flash;
  logic                   rd_req;
  flash_addr_t            rd_addr;
  logic                   rd_busy;
  logic                   rd_valid;
  reg_word_t              rd_data;
  logic                   reg_valid;
  logic                   reg_write;
  logic [`REG_ADDR_W-1:0] reg_addr;
  reg_word_t              reg_wdata;
  reg_word_t              reg_rdata;
  logic                   spi_sck;
  logic                   spi_sck_en;
  csb_t                   spi_csb;
  csb_t                   spi_csb_en;
  sd_t                    spi_sd;
  sd_t                    spi_sd_en;
  sd_t                    spi_sd_in;
  int unsigned            valid_cnt = 0;
  logic                   watch_cs0 = 1'b0;
  logic                   watch_sck = 1'b0;

  tb_clk_gen clk_gen_inst (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  tb_flash_model flash_model_inst (
    .sck_i (spi_sck),
    .csb_i (spi_csb),
    .sd_i  (spi_sd),
    .sd_o  (spi_sd_in)
  );

  spi_subsystem spi_subsystem_inst (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .use_flash_i  (use_flash),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_busy_o    (rd_busy),
    .rd_valid_o   (rd_valid),
    .rd_data_o    (rd_data),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .spi_sck_o    (spi_sck),
    .spi_sck_en_o (spi_sck_en),
    .spi_csb_o    (spi_csb),
    .spi_csb_en_o (spi_csb_en),
    .spi_sd_o     (spi_sd),
    .spi_sd_en_o  (spi_sd_en),
    .spi_sd_i     (spi_sd_in)
  );

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp));
    end
  endtask

  // Pulse count and pad checks at mid-cycle
  always @(negedge clk) begin
    if (rd_valid) begin
      valid_cnt <= valid_cnt + 1;
    end
    if (arst_n) begin
      check_value("spi_sck_en_o", 32'(spi_sck_en), 32'd1);
      check_value("spi_csb_en_o", 32'(spi_csb_en), 32'({`SPI_NUM_CS{1'b1}}));
      // Only MOSI is enabled, and only while a chip select is low
      check_value("spi_sd_en_o", 32'(spi_sd_en),
                  32'(spi_csb != {`SPI_NUM_CS{1'b1}}));
    end
    if (watch_cs0) begin
      check_value("spi_csb_o[0]", 32'(spi_csb[0]), 32'd1);
    end
    if (watch_sck) begin
      check_value("spi_sck_o", 32'(spi_sck), 32'd0);
    end
  end

  task automatic write_reg(input host_reg_e addr, input reg_word_t data);
    @(posedge clk);
    #1;
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  // Read data is taken one cycle after the strobe
  task automatic read_reg(input host_reg_e addr, output reg_word_t data);
    @(posedge clk);
    #1;
    reg_valid = 1'b1;
    reg_write = 1'b0;
    reg_addr  = addr;
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic wait_host_idle();
    reg_word_t   status;
    int unsigned polls;
    status = 32'h1;
    polls  = 0;
    while (status[0] && polls < WAIT_CYCLES) begin
      read_reg(REG_STATUS, status);
      polls++;
    end
    assert (!status[0]) else stop_run("Host controller stayed busy, STATUS polling gave up");
  endtask

  task automatic pulse_read(input flash_addr_t addr);
    @(posedge clk);
    #1;
    rd_req  = 1'b1;
    rd_addr = addr;
    @(posedge clk);
    #1;
    rd_req = 1'b0;
  endtask

  task automatic wait_valid(output reg_word_t data);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!rd_valid && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    assert (rd_valid) else stop_run("rd_valid_o never pulsed after a flash read request");
    data = rd_data;
  endtask

  task automatic run_row(input row_t row);
    reg_word_t   got;
    int unsigned valid_before;
    @(posedge clk);
    #1;
    use_flash = row.sel;
    repeat (2) @(posedge clk);
    #1;
    case (row.kind)
      K_REG: begin
        write_reg(REG_CTRL, reg_word_t'(row.arg));
        read_reg(REG_CTRL, got);
        check_value("reg_rdata_o", got, row.exp);
      end
      K_HOST: begin
        write_reg(REG_CTRL, 32'd1);
        watch_cs0 = 1'b1;
        write_reg(REG_TXDATA, reg_word_t'(row.arg[7:0]));
        wait_host_idle();
        watch_cs0 = 1'b0;
        read_reg(REG_RXDATA, got);
        check_value("reg_rdata_o", got, row.exp);
      end
      default: begin
        valid_before = valid_cnt;
        watch_cs0    = !row.sel;
        watch_sck    = !row.sel;
        pulse_read(row.arg);
        @(negedge clk);
        check_value("rd_busy_o", 32'(rd_busy), 32'd1);
        if (row.kind == K_FLASH_DBL) begin
          repeat (4) @(negedge clk);
          check_value("rd_busy_o", 32'(rd_busy), 32'd1);
          pulse_read(row.arg + 24'h40);
        end
        wait_valid(got);
        check_value("rd_data_o", got, row.exp);
        // Room for a wrongly queued second read to show up
        repeat ((row.kind == K_FLASH_DBL) ? READ_CYCLES : 4) @(negedge clk);
        check_value("rd_valid_o pulses", 32'(valid_cnt - valid_before), 32'd1);
        check_value("rd_busy_o", 32'(rd_busy), 32'd0);
        watch_cs0 = 1'b0;
        watch_sck = 1'b0;
      end
    endcase
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_run("Watchdog expired before all table rows were done");
  end

  initial begin
    reg_word_t got;
    use_flash = 1'b0;
    rd_req    = 1'b0;
    rd_addr   = '0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    @(posedge arst_n);
    @(negedge clk);
    check_value("spi_csb_o", 32'(spi_csb), 32'({`SPI_NUM_CS{1'b1}}));
    check_value("spi_sck_o", 32'(spi_sck), 32'd0);
    check_value("spi_sd_en_o", 32'(spi_sd_en), 32'd0);
    check_value("rd_busy_o", 32'(rd_busy), 32'd0);
    check_value("rd_valid_o", 32'(rd_valid), 32'd0);
    read_reg(REG_RXDATA, got);
    check_value("reg_rdata_o", got, 32'd0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
common/spi_bus_pkg.sv
common/spi_pad_pkg.sv
common/spi_pad_if.sv
hw/flash_reader/flash_reader.sv
hw/spi_host/spi_host_ctrl.sv
hw/spi_pad_mux.sv
hw/spi_subsystem.sv
tests/tb_clk_gen.sv
tests/tb_flash_model.sv
tests/tb_spi_subsystem.sv

/* Bender.yml */
package:
  name: spi_subsystem

export_include_dirs:
  - common

sources:
  - common/spi_bus_pkg.sv
  - common/spi_pad_pkg.sv
  - common/spi_pad_if.sv
  - hw/flash_reader/flash_reader.sv
  - hw/spi_host/spi_host_ctrl.sv
  - hw/spi_pad_mux.sv
  - hw/spi_subsystem.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_flash_model.sv
      - tests/tb_spi_subsystem.sv
